// ==== logic/clk_sel_defines.svh ====
`ifndef CLK_SEL_DEFINES_SVH
`define CLK_SEL_DEFINES_SVH

// Measurement window of the clk_ext monitor, in clk_int cycles
`define CLK_SEL_WINDOW 256

// Width of the window counter, enough to hold CLK_SEL_WINDOW - 1
`define CLK_SEL_WIN_W 8

// Fewer rising edges than this in one window means clk_ext has stopped
`define CLK_SEL_MIN_EDGES 8

// Relock time after a change of source, in clk_int cycles
`define CLK_SEL_LOCK_CYCLES 64

// Width of the relock timer, enough to hold CLK_SEL_LOCK_CYCLES
`define CLK_SEL_LOCK_W 7

// Width of the measured rate
`define CLK_SEL_RATE_W 16

// Width of the saturating switch counter
`define CLK_SEL_SWITCH_W 16

`endif

// ==== logic/clk_mon_pkg.sv ====
`default_nettype none

`include "clk_sel_defines.svh"

package clk_mon_pkg;

    // Rising edges of clk_ext counted over one window
    typedef logic [`CLK_SEL_RATE_W-1:0] rate_t;

    // Monitor result as seen by the control and the registers
    //   rate     last published edge count
    //   stopped  set while clk_ext delivers too few edges
    //   update   one-cycle pulse in the last cycle of every window
    typedef struct packed {
        rate_t rate;
        logic  stopped;
        logic  update;
    } mon_result_t;

    // Monitor state right after reset, before the first window ends
    localparam mon_result_t MON_RESET = '{
        rate:    '0,
        stopped: 1'b1,
        update:  1'b0
    };

endpackage

`default_nettype wire

// ==== logic/clk_reg_pkg.sv ====
`default_nettype none

package clk_reg_pkg;

    localparam int REG_DATA_W = 32;

    // Register index on the plain-strobe bus
    typedef logic [1:0] reg_addr_t;

    localparam reg_addr_t REG_CTRL     = 2'd0;
    localparam reg_addr_t REG_STATUS   = 2'd1;
    localparam reg_addr_t REG_RATE     = 2'd2;
    localparam reg_addr_t REG_SWITCHES = 2'd3;

    // Bus request, wr and rd are single-cycle strobes
    typedef struct packed {
        logic                  wr;
        logic                  rd;
        reg_addr_t             addr;
        logic [REG_DATA_W-1:0] wdata;
    } reg_req_t;

    // Read response, rvalid pulses one cycle after rd
    typedef struct packed {
        logic                  rvalid;
        logic [REG_DATA_W-1:0] rdata;
    } reg_rsp_t;

    // Layout of the ctrl word, only bit 0 is implemented
    typedef struct packed {
        logic [REG_DATA_W-2:0] reserved;
        logic                  int_select;
    } ctrl_t;

    // Status bits, read back zero-extended in register 1
    typedef struct packed {
        logic ext_active;
        logic use_ext;
        logic locked;
    } sel_status_t;

endpackage

`default_nettype wire

// ==== logic/clk_edge_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_sel_defines.svh"

module clk_edge_counter
    import clk_mon_pkg::*;
(
    input  logic        clk_int,
    input  logic        rst_n,
    input  logic        clk_ext,
    output mon_result_t mon
);

    localparam int WIN_W  = `CLK_SEL_WIN_W;
    localparam int RATE_W = `CLK_SEL_RATE_W;

    localparam logic [WIN_W-1:0]  WIN_LAST  = WIN_W'(`CLK_SEL_WINDOW - 1);
    localparam logic [RATE_W-1:0] MIN_EDGES = RATE_W'(`CLK_SEL_MIN_EDGES);

    // clk_ext is only data here, sampled by clk_int
    logic [1:0]        ext_sync;
    logic              ext_prev;
    logic              ext_rise;

    logic [WIN_W-1:0]  win_cnt;
    logic              win_end;
    logic [RATE_W-1:0] edge_cnt;
    logic [RATE_W-1:0] edge_total;

    rate_t             rate_q;
    logic              stopped_q;

    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            ext_sync <= '0;
            ext_prev <= 1'b0;
        end else begin
            ext_sync <= {ext_sync[0], clk_ext};
            ext_prev <= ext_sync[1];
        end
    end

    assign ext_rise = ext_sync[1] & ~ext_prev;

    // Window runs 0 .. WINDOW-1, the first one starts right after reset
    assign win_end = (win_cnt == WIN_LAST);

    // An edge seen in the last cycle still belongs to this window
    assign edge_total = edge_cnt + RATE_W'(ext_rise);

    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            win_cnt   <= '0;
            edge_cnt  <= '0;
            rate_q    <= MON_RESET.rate;
            stopped_q <= MON_RESET.stopped;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            if (win_end) begin
                edge_cnt  <= '0;
                rate_q    <= edge_total;
                stopped_q <= (edge_total < MIN_EDGES);
            end else begin
                edge_cnt <= edge_total;
            end
        end
    end

    // Rate and stopped become valid in the cycle after the pulse
    assign mon.rate    = rate_q;
    assign mon.stopped = stopped_q;
    assign mon.update  = win_end;

endmodule

`default_nettype wire

// ==== logic/clk_sel_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_sel_defines.svh"

module clk_sel_control
    import clk_mon_pkg::*;
    import clk_reg_pkg::*;
(
    input  logic                         clk_int,
    input  logic                         rst_n,
    input  mon_result_t                  mon,
    input  logic                         int_select,
    output logic                         clk_sel,
    output logic                         locked,
    output logic                         ext_active,
    output sel_status_t                  status,
    output logic [`CLK_SEL_SWITCH_W-1:0] switches
);

    localparam int LOCK_W = `CLK_SEL_LOCK_W;
    localparam int SW_W   = `CLK_SEL_SWITCH_W;

    localparam logic [LOCK_W-1:0] LOCK_LOAD = LOCK_W'(`CLK_SEL_LOCK_CYCLES);

    logic              use_ext_next;
    logic              use_ext;
    logic              src_change;
    logic [LOCK_W-1:0] lock_timer;
    logic [SW_W-1:0]   switch_cnt;
    logic              ext_active_q;

    // External source only while it runs and software does not force internal
    assign use_ext_next = ~mon.stopped & ~int_select;
    assign src_change   = (use_ext_next != use_ext);

    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            use_ext      <= 1'b0;
            ext_active_q <= 1'b0;
        end else begin
            use_ext      <= use_ext_next;
            ext_active_q <= ~mon.stopped;
        end
    end

    // Relock timer
    // Loaded during reset so the first lock comes LOCK_CYCLES after release
    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            lock_timer <= LOCK_LOAD;
        end else if (src_change) begin
            lock_timer <= LOCK_LOAD;
        end else if (lock_timer != '0) begin
            lock_timer <= lock_timer - 1'b1;
        end
    end

    // Switch counter sticks at all ones
    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            switch_cnt <= '0;
        end else if (src_change && (switch_cnt != '1)) begin
            switch_cnt <= switch_cnt + 1'b1;
        end
    end

    // Locked drops with the reload, so in the same cycle use_ext flips
    assign locked     = (lock_timer == '0);
    assign clk_sel    = use_ext;
    assign ext_active = ext_active_q;
    assign switches   = switch_cnt;

    assign status.ext_active = ext_active_q;
    assign status.use_ext    = use_ext;
    assign status.locked     = locked;

endmodule

`default_nettype wire

// ==== logic/clk_reg_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_sel_defines.svh"

module clk_reg_block
    import clk_mon_pkg::*;
    import clk_reg_pkg::*;
(
    input  logic                         clk_int,
    input  logic                         rst_n,
    input  reg_req_t                     reg_req,
    output reg_rsp_t                     reg_rsp,
    output logic                         int_select,
    input  mon_result_t                  mon,
    input  sel_status_t                  status,
    input  logic [`CLK_SEL_SWITCH_W-1:0] switches
);

    ctrl_t                 ctrl_q;
    logic                  update_d;
    rate_t                 rate_q;
    logic                  wr_ctrl;
    logic                  rd_hit;
    logic [REG_DATA_W-1:0] rd_mux;
    logic                  rvalid_q;
    logic [REG_DATA_W-1:0] rdata_q;

    // Write wins over a read in the same cycle
    assign wr_ctrl = reg_req.wr && (reg_req.addr == REG_CTRL);
    assign rd_hit  = reg_req.rd && !reg_req.wr;

    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (wr_ctrl) begin
            ctrl_q.int_select <= reg_req.wdata[0];
        end
    end

    // Rate is published the cycle after the window end pulse
    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            update_d <= 1'b0;
            rate_q   <= '0;
        end else begin
            update_d <= mon.update;
            if (update_d) begin
                rate_q <= mon.rate;
            end
        end
    end

    always_comb begin
        case (reg_req.addr)
            REG_CTRL:     rd_mux = ctrl_q;
            REG_STATUS:   rd_mux = REG_DATA_W'(status);
            REG_RATE:     rd_mux = REG_DATA_W'(rate_q);
            REG_SWITCHES: rd_mux = REG_DATA_W'(switches);
            default:      rd_mux = '0;
        endcase
    end

    // Read data follows the strobe by one cycle
    always_ff @(posedge clk_int) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_hit;
        end
    end

    always_ff @(posedge clk_int) begin
        if (rd_hit) begin
            rdata_q <= rd_mux;
        end
    end

    assign reg_rsp.rvalid = rvalid_q;
    assign reg_rsp.rdata  = rdata_q;
    assign int_select     = ctrl_q.int_select;

endmodule

`default_nettype wire

// ==== logic/clk_sel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_sel_defines.svh"

module clk_sel_top
    import clk_mon_pkg::*;
    import clk_reg_pkg::*;
(
    input  logic     clk_int,
    input  logic     rst_n,
    input  logic     clk_ext,
    input  reg_req_t reg_req,
    output reg_rsp_t reg_rsp,
    output logic     clk_sel,
    output logic     locked,
    output logic     ext_active
);

    mon_result_t                  mon;
    logic                         int_select;
    sel_status_t                  status;
    logic [`CLK_SEL_SWITCH_W-1:0] switches;

    // Rate and stopped detection of clk_ext
    clk_edge_counter u_edge_counter (
        .clk_int (clk_int),
        .rst_n   (rst_n),
        .clk_ext (clk_ext),
        .mon     (mon)
    );

    // Source choice and relock
    clk_sel_control u_control (
        .clk_int    (clk_int),
        .rst_n      (rst_n),
        .mon        (mon),
        .int_select (int_select),
        .clk_sel    (clk_sel),
        .locked     (locked),
        .ext_active (ext_active),
        .status     (status),
        .switches   (switches)
    );

    // Software view
    clk_reg_block u_regs (
        .clk_int    (clk_int),
        .rst_n      (rst_n),
        .reg_req    (reg_req),
        .reg_rsp    (reg_rsp),
        .int_select (int_select),
        .mon        (mon),
        .status     (status),
        .switches   (switches)
    );

endmodule

`default_nettype wire

// ==== testbench/clk_sel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "clk_sel_defines.svh"

module clk_sel_tb
    import clk_mon_pkg::*;
    import clk_reg_pkg::*;
;

    localparam int NUM_ROWS      = 9;
    localparam int WINDOW        = `CLK_SEL_WINDOW;
    localparam int LOCK_LIMIT    = `CLK_SEL_LOCK_CYCLES + 2;
    localparam int SETTLE_CYCLES = 8;

    // Three windows per row, two more for reset and the closing reads
    localparam longint WATCHDOG_NS = longint'(NUM_ROWS * 3 + 2) * WINDOW * 10;

    // One line of the stimulus table
    typedef struct packed {
        logic [15:0] period_ns;
        logic        force_int;
        logic        exp_ext_active;
        logic        exp_clk_sel;
        rate_t       exp_rate;
    } stim_row_t;

    logic     clk_int;
    logic     rst_n;
    logic     clk_ext;
    reg_req_t reg_req;
    reg_rsp_t reg_rsp;
    logic     clk_sel;
    logic     locked;
    logic     ext_active;

    stim_row_t rows [NUM_ROWS];
    int        ext_half = 0;
    int        error_count = 0;
    int        check_count = 0;
    int        seen_changes = 0;
    int        expected_switches = 0;
    logic      last_sel = 1'b0;
    logic      prev_exp_sel = 1'b0;
    logic      relock_pending = 1'b0;
    int        relock_wait = 0;

    clk_sel_top dut (
        .clk_int    (clk_int),
        .rst_n      (rst_n),
        .clk_ext    (clk_ext),
        .reg_req    (reg_req),
        .reg_rsp    (reg_rsp),
        .clk_sel    (clk_sel),
        .locked     (locked),
        .ext_active (ext_active)
    );

    initial begin
        clk_int = 1'b0;
        forever #5 clk_int = ~clk_int;
    end

    // External clock, held low while the row asks for a stopped source
    initial begin
        clk_ext = 1'b0;
        forever begin
            if (ext_half == 0) begin
                clk_ext = 1'b0;
                wait (ext_half != 0);
            end else begin
                #(ext_half);
                clk_ext = ~clk_ext;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    function automatic stim_row_t make_row(input int period, input logic force_int,
                                           input logic act, input logic sel, input int rate);
        return '{period_ns: 16'(period), force_int: force_int, exp_ext_active: act,
                 exp_clk_sel: sel, exp_rate: rate_t'(rate)};
    endfunction

    function automatic sel_status_t port_status();
        return '{ext_active: ext_active, use_ext: clk_sel, locked: locked};
    endfunction

    function automatic sel_status_t expected_status(input stim_row_t row);
        return '{ext_active: row.exp_ext_active, use_ext: row.exp_clk_sel, locked: 1'b1};
    endfunction

    task automatic note_failure(input string msg);
        $display("ERROR @ %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic check_rate(input rate_t got, input rate_t exp, input string what);
        int diff;
        diff = int'(got) - int'(exp);
        check_count++;
        if (diff > 1 || diff < -1) begin
            $display("CHECK FAILED @ %0t ns: %s got %0d expected %0d +-1", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_status(input sel_status_t got, input sel_status_t exp,
                                input string what);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t ns: %s got %b expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED @ %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic do_write(input reg_addr_t addr, input logic [31:0] data);
        @(posedge clk_int);
        #1;
        reg_req.wr    = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        @(posedge clk_int);
        #1;
        reg_req.wr    = 1'b0;
        reg_req.wdata = '0;
    endtask

    // Read strobe for one cycle, rvalid must follow exactly one cycle later
    task automatic do_read(input reg_addr_t addr, output logic [31:0] data);
        @(posedge clk_int);
        #1;
        reg_req.rd   = 1'b1;
        reg_req.addr = addr;
        @(negedge clk_int);
        if (reg_rsp.rvalid !== 1'b0) note_failure("rvalid was high before the read was taken");
        @(posedge clk_int);
        #1;
        reg_req.rd = 1'b0;
        @(negedge clk_int);
        if (reg_rsp.rvalid !== 1'b1) note_failure("rvalid missing one cycle after the read");
        data = reg_rsp.rdata;
        @(negedge clk_int);
        if (reg_rsp.rvalid !== 1'b0) note_failure("rvalid stayed high for more than one cycle");
    endtask

    // Watch clk_sel, every change must drop locked and relock in time
    always @(negedge clk_int) begin
        if (rst_n) begin
            if (clk_sel !== last_sel) begin
                seen_changes++;
                if (locked !== 1'b0) note_failure("locked stayed high after clk_sel changed");
                relock_wait    = 0;
                relock_pending = 1'b1;
            end else if (relock_pending) begin
                if (locked === 1'b1) begin
                    relock_pending = 1'b0;
                end else begin
                    relock_wait++;
                    if (relock_wait >= LOCK_LIMIT) begin
                        note_failure("locked did not return after a change of clk_sel");
                        relock_pending = 1'b0;
                    end
                end
            end
            last_sel = clk_sel;
        end
    end

    task automatic load_rows();
        rows[0] = make_row(40, 1'b0, 1'b1, 1'b1, 64);
        rows[1] = make_row(40, 1'b1, 1'b1, 1'b0, 64);
        rows[2] = make_row(40, 1'b0, 1'b1, 1'b1, 64);
        rows[3] = make_row(0, 1'b0, 1'b0, 1'b0, 0);
        rows[4] = make_row(80, 1'b0, 1'b1, 1'b1, 32);
        rows[5] = make_row(64, 1'b1, 1'b1, 1'b0, 40);
        rows[6] = make_row(128, 1'b0, 1'b1, 1'b1, 20);
        rows[7] = make_row(0, 1'b1, 1'b0, 1'b0, 0);
        rows[8] = make_row(160, 1'b0, 1'b1, 1'b1, 16);
    endtask

    task automatic check_after_reset();
        int cycles;
        logic [31:0] data;
        cycles = 0;
        @(negedge clk_int);
        check_status(port_status(), '0, "ports after reset");
        while (locked !== 1'b1 && cycles < LOCK_LIMIT) begin
            @(negedge clk_int);
            cycles++;
        end
        if (locked !== 1'b1) note_failure("locked did not rise after reset release");
        do_read(REG_SWITCHES, data);
        check_word(data, '0, "switches after reset");
        do_read(REG_CTRL, data);
        check_word(data, '0, "ctrl after reset");
    endtask

    // Reads every register in a random order and tries to write the read-only ones
    task automatic probe_registers(input stim_row_t row);
        int order [4];
        int pick;
        int held;
        logic [31:0] data;
        logic [31:0] again;
        for (int i = 0; i < 4; i++) order[i] = i;
        for (int i = 3; i > 0; i--) begin
            pick = int'($urandom % 32'(i + 1));
            held = order[i];
            order[i] = order[pick];
            order[pick] = held;
        end
        for (int i = 0; i < 4; i++) begin
            case (order[i])
                0: begin
                    do_read(REG_CTRL, data);
                    check_word(data, {31'b0, row.force_int}, "ctrl register");
                end
                1: begin
                    do_read(REG_STATUS, data);
                    check_status(sel_status_t'(data[2:0]), expected_status(row), "status register");
                    check_word(data >> 3, '0, "status upper bits");
                    do_write(REG_STATUS, '1);
                    do_read(REG_STATUS, again);
                    check_word(again, data, "status after write");
                end
                2: begin
                    do_read(REG_RATE, data);
                    check_rate(rate_t'(data[15:0]), row.exp_rate, "rate register");
                    check_word(data >> 16, '0, "rate upper bits");
                    do_write(REG_RATE, '1);
                    do_read(REG_RATE, again);
                    check_rate(rate_t'(again[15:0]), rate_t'(data[15:0]), "rate after write");
                end
                default: begin
                    do_read(REG_SWITCHES, data);
                    check_word(data, 32'(expected_switches), "switches register");
                    do_write(REG_SWITCHES, '1);
                    do_read(REG_SWITCHES, again);
                    check_word(again, data, "switches after write");
                end
            endcase
        end
    endtask

    task automatic run_row(input stim_row_t row);
        @(posedge clk_int);
        #1;
        ext_half = int'(row.period_ns) / 2;
        do_write(REG_CTRL, {31'b0, row.force_int});
        if (row.exp_clk_sel != prev_exp_sel) expected_switches++;
        prev_exp_sel = row.exp_clk_sel;
        repeat (2 * WINDOW + SETTLE_CYCLES) @(posedge clk_int);
        @(negedge clk_int);
        check_status(port_status(), expected_status(row), "clk_sel, locked, ext_active ports");
        check_word(32'(seen_changes), 32'(expected_switches), "clk_sel changes seen");
        probe_registers(row);
    endtask

    initial begin
        void'($urandom(32'h89f67188));
        rst_n   = 1'b0;
        reg_req = '0;
        load_rows();
        repeat (10) @(posedge clk_int);
        #1;
        rst_n = 1'b1;
        check_after_reset();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("Run complete: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
logic/clk_mon_pkg.sv
logic/clk_reg_pkg.sv
logic/clk_edge_counter.sv
logic/clk_sel_control.sv
logic/clk_reg_block.sv
logic/clk_sel_top.sv
testbench/clk_sel_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the clock selector testbench with Verilator and runs it.
# The run passes only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module clk_sel_tb \
    -f all.f -o clk_sel_sim \
    && ./obj_dir/clk_sel_sim | tee /dev/stderr | grep -Fx '>>> PASS' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
